// File: cin_link_pkg.sv
`default_nettype none

// Data path constants and the lane to capture record for the CIN receiver
package cin_link_pkg;

    // Eight parallel CIN lanes
    localparam int CIN_LANES = 8;

    // One nibble per rxclk out of the 1:4 deserializer
    localparam int CIN_NIB_W = 4;

    // Bitslip offset covers every position in a nibble
    localparam int CIN_SLIP_W = 2;

    // Input delay tap width, as on the IDELAY count port
    localparam int CIN_TAP_W = 6;

    // Lane select width for tap readback and load
    localparam int CIN_SEL_W = $clog2(CIN_LANES);

    // Training nibble, first bit in time is the MSB
    // All four rotations differ so only one offset matches
    localparam logic [CIN_NIB_W-1:0] CIN_TRAIN = 4'b1000;

    // Consecutive aligned words before a lane counts as locked
    localparam int CIN_LOCK_COUNT = 4;

    // Run counter must hold CIN_LOCK_COUNT itself when saturated
    localparam int CIN_RUN_W = $clog2(CIN_LOCK_COUNT + 1);

    // What a lane hands to the capture block every cycle
    typedef struct packed {
        // Recovered nibble after bitslip
        logic [CIN_NIB_W-1:0] nibble;
        // Recovered nibble equals the training pattern
        logic                 train_match;
        // Tap currently held for this lane
        logic [CIN_TAP_W-1:0] tap;
    } cin_lane_out_t;

endpackage

`default_nettype wire

// File: cin_ctrl_pkg.sv
`default_nettype none

// Command encoding and per-lane control for the CIN receiver
package cin_ctrl_pkg;

    import cin_link_pkg::*;

    // Command word layout
    localparam int CMD_W    = 16;
    localparam int CMD_OP_W = 2;

    // Opcodes in the top two bits of every command
    localparam logic [CMD_OP_W-1:0] CMD_LOAD_DELAY   = 2'd0;
    localparam logic [CMD_OP_W-1:0] CMD_BITSLIP      = 2'd1;
    localparam logic [CMD_OP_W-1:0] CMD_SERDES_RESET = 2'd2;
    localparam logic [CMD_OP_W-1:0] CMD_READ_TAP     = 2'd3;

    // Single lane addressed with a tap value
    typedef struct packed {
        logic [CMD_OP_W-1:0]                          opcode;
        logic [CIN_SEL_W-1:0]                         lane;
        logic [CMD_W-CMD_OP_W-CIN_SEL_W-CIN_TAP_W-1:0] rsvd;
        logic [CIN_TAP_W-1:0]                         tap;
    } cin_cmd_tap_t;

    // Any set of lanes addressed by a mask
    typedef struct packed {
        logic [CMD_OP_W-1:0]                 opcode;
        logic [CMD_W-CMD_OP_W-CIN_LANES-1:0] rsvd;
        logic [CIN_LANES-1:0]                lane_mask;
    } cin_cmd_mask_t;

    // Same 16 bits, read one way or the other depending on opcode
    typedef union packed {
        cin_cmd_tap_t  tap_view;
        cin_cmd_mask_t mask_view;
    } cin_cmd_t;

    // Decoder to lane, pulses are one cycle wide
    typedef struct packed {
        logic                 bitslip;
        logic                 serdes_reset;
        logic                 delay_load;
        logic [CIN_TAP_W-1:0] tap;
    } cin_lane_ctrl_t;

endpackage

`default_nettype wire

// File: cin_ctrl_decode.sv
`timescale 1ns/1ps
`default_nettype none

// Turns command strobes into registered per-lane pulses
// Stands in for the VIO probes used on the bench
module cin_ctrl_decode
    import cin_link_pkg::*, cin_ctrl_pkg::*;
(
    input  wire logic                                  rxclk,
    input  wire logic                                  reset,
    input  wire logic                                  cmd_strobe,
    input  wire cin_cmd_t                              cmd,
    output      cin_lane_ctrl_t [CIN_LANES-1:0]        lane_ctrl,
    output      logic           [CIN_SEL_W-1:0]        rd_lane
);

    // Opcode sits in the same bits for both views
    logic [CMD_OP_W-1:0] opcode;

    // Next-cycle pulse vectors, one bit per lane
    logic [CIN_LANES-1:0] slip_d;
    logic [CIN_LANES-1:0] sreset_d;
    logic [CIN_LANES-1:0] load_d;

    // Registered pulses
    logic [CIN_LANES-1:0] slip_q;
    logic [CIN_LANES-1:0] sreset_q;
    logic [CIN_LANES-1:0] load_q;

    // Tap value broadcast to all lanes
    logic [CIN_TAP_W-1:0] load_tap;

    assign opcode = cmd.tap_view.opcode;

    // Decode this cycle's command
    always_comb begin
        slip_d   = '0;
        sreset_d = '0;
        load_d   = '0;
        if (cmd_strobe) begin
            case (opcode)
                CMD_LOAD_DELAY: begin
                    // One-hot on the addressed lane
                    for (int i = 0; i < CIN_LANES; i++) begin
                        load_d[i] = (cmd.tap_view.lane == CIN_SEL_W'(i));
                    end
                end
                CMD_BITSLIP: begin
                    slip_d = cmd.mask_view.lane_mask;
                end
                CMD_SERDES_RESET: begin
                    sreset_d = cmd.mask_view.lane_mask;
                end
                default: begin
                    // Read tap only moves rd_lane
                end
            endcase
        end
    end

    // Pulses and readback select
    always_ff @(posedge rxclk) begin
        if (reset) begin
            slip_q   <= '0;
            sreset_q <= '0;
            load_q   <= '0;
            rd_lane  <= '0;
        end else begin
            slip_q   <= slip_d;
            sreset_q <= sreset_d;
            load_q   <= load_d;
            if (cmd_strobe && opcode == CMD_READ_TAP) begin
                rd_lane <= cmd.tap_view.lane;
            end
        end
    end

    // Tap only matters alongside a load pulse
    always_ff @(posedge rxclk) begin
        if (cmd_strobe && opcode == CMD_LOAD_DELAY) begin
            load_tap <= cmd.tap_view.tap;
        end
    end

    // Fan out into one control record per lane
    always_comb begin
        for (int i = 0; i < CIN_LANES; i++) begin
            lane_ctrl[i].bitslip      = slip_q[i];
            lane_ctrl[i].serdes_reset = sreset_q[i];
            lane_ctrl[i].delay_load   = load_q[i];
            lane_ctrl[i].tap          = load_tap;
        end
    end

endmodule

`default_nettype wire

// File: cin_lane.sv
`timescale 1ns/1ps
`default_nettype none

// One CIN lane behind a networking-mode 1:4 deserializer
// Raw nibble arrives MSB first in time
module cin_lane
    import cin_link_pkg::*, cin_ctrl_pkg::*;
(
    input  wire logic                 rxclk,
    input  wire logic                 reset,
    input  wire logic [CIN_NIB_W-1:0] raw,
    input  wire cin_lane_ctrl_t       ctrl,
    output      cin_lane_out_t        lane_out
);

    // Raw nibble from the previous cycle
    logic [CIN_NIB_W-1:0] prev_raw;

    // Current bitslip offset
    logic [CIN_SLIP_W-1:0] slip;

    // Held delay tap with no analog delay behind it
    logic [CIN_TAP_W-1:0] tap;

    // Eight bits of history shifted by the offset
    logic [2*CIN_NIB_W-1:0] window;

    // Recovered nibble before the output register
    logic [CIN_NIB_W-1:0] nib_d;

    // Output register
    logic [CIN_NIB_W-1:0] nib_q;
    logic                 match_q;

    // Older nibble on top so a right shift pulls in its low bits
    assign window = {prev_raw, raw} >> slip;
    assign nib_d  = window[CIN_NIB_W-1:0];

    // History, offset and output register
    always_ff @(posedge rxclk) begin
        if (reset || ctrl.serdes_reset) begin
            // Deserializer reset drops alignment but not the tap
            prev_raw <= '0;
            slip     <= '0;
            nib_q    <= '0;
            match_q  <= 1'b0;
        end else begin
            prev_raw <= raw;
            nib_q    <= nib_d;
            match_q  <= (nib_d == CIN_TRAIN);
            // Wraps after four slips
            if (ctrl.bitslip) begin
                slip <= slip + CIN_SLIP_W'(1);
            end
        end
    end

    // Tap register survives a deserializer reset
    always_ff @(posedge rxclk) begin
        if (reset) begin
            tap <= '0;
        end else if (ctrl.delay_load) begin
            tap <= ctrl.tap;
        end
    end

    // To capture
    assign lane_out.nibble      = nib_q;
    assign lane_out.train_match = match_q;
    assign lane_out.tap         = tap;

endmodule

`default_nettype wire

// File: cin_capture.sv
`timescale 1ns/1ps
`default_nettype none

// Collects all lanes into one word with alignment and lock status
module cin_capture
    import cin_link_pkg::*;
(
    input  wire logic                                  rxclk,
    input  wire logic                                  reset,
    input  wire cin_lane_out_t [CIN_LANES-1:0]         lane_out,
    input  wire logic          [CIN_SEL_W-1:0]         rd_lane,
    output      logic          [CIN_LANES*CIN_NIB_W-1:0] cin_word,
    output      logic          [CIN_LANES-1:0]         aligned,
    output      logic          [CIN_LANES-1:0]         locked,
    output      logic          [CIN_TAP_W-1:0]         rd_tap
);

    // Saturating count of aligned words in a row per lane
    logic [CIN_RUN_W-1:0] run_cnt [CIN_LANES];

    // Word, alignment and lock
    always_ff @(posedge rxclk) begin
        if (reset) begin
            cin_word <= '0;
            aligned  <= '0;
            locked   <= '0;
            for (int i = 0; i < CIN_LANES; i++) begin
                run_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < CIN_LANES; i++) begin
                // Lane 0 lands in the low nibble
                cin_word[i*CIN_NIB_W +: CIN_NIB_W] <= lane_out[i].nibble;
                aligned[i] <= lane_out[i].train_match;
                if (lane_out[i].train_match) begin
                    if (run_cnt[i] != CIN_RUN_W'(CIN_LOCK_COUNT)) begin
                        run_cnt[i] <= run_cnt[i] + CIN_RUN_W'(1);
                    end
                    // Three already counted plus this one
                    locked[i] <= (run_cnt[i] >= CIN_RUN_W'(CIN_LOCK_COUNT - 1));
                end else begin
                    // One miss drops lock straight away
                    run_cnt[i] <= '0;
                    locked[i]  <= 1'b0;
                end
            end
        end
    end

    // Tap readback of the selected lane
    always_ff @(posedge rxclk) begin
        if (reset) begin
            rd_tap <= '0;
        end else begin
            rd_tap <= lane_out[rd_lane].tap;
        end
    end

endmodule

`default_nettype wire

// File: turf_cin_rx.sv
`timescale 1ns/1ps
`default_nettype none

// Receive side of the TURF CIN link at the rxclk rate
module turf_cin_rx
    import cin_link_pkg::*, cin_ctrl_pkg::*;
(
    input  wire logic                                  rxclk,
    input  wire logic                                  reset,
    // Lane 0 in the low bits
    input  wire logic [CIN_LANES-1:0][CIN_NIB_W-1:0]   cin_raw,
    input  wire logic                                  cmd_strobe,
    input  wire cin_cmd_t                              cmd,
    output      logic [CIN_LANES*CIN_NIB_W-1:0]        cin_word,
    output      logic [CIN_LANES-1:0]                  aligned,
    output      logic [CIN_LANES-1:0]                  locked,
    output      logic [CIN_TAP_W-1:0]                  rd_tap
);

    // Decoder to lanes
    cin_lane_ctrl_t [CIN_LANES-1:0] lane_ctrl;

    // Readback select to capture
    logic [CIN_SEL_W-1:0] rd_lane;

    // Lanes to capture
    cin_lane_out_t [CIN_LANES-1:0] lane_out;

    cin_ctrl_decode u_decode (
        .rxclk      (rxclk),
        .reset      (reset),
        .cmd_strobe (cmd_strobe),
        .cmd        (cmd),
        .lane_ctrl  (lane_ctrl),
        .rd_lane    (rd_lane)
    );

    // Identical lanes
    for (genvar g = 0; g < CIN_LANES; g++) begin : g_lane
        cin_lane u_lane (
            .rxclk    (rxclk),
            .reset    (reset),
            .raw      (cin_raw[g]),
            .ctrl     (lane_ctrl[g]),
            .lane_out (lane_out[g])
        );
    end

    cin_capture u_capture (
        .rxclk    (rxclk),
        .reset    (reset),
        .lane_out (lane_out),
        .rd_lane  (rd_lane),
        .cin_word (cin_word),
        .aligned  (aligned),
        .locked   (locked),
        .rd_tap   (rd_tap)
    );

endmodule

`default_nettype wire

// File: turf_cin_rx_chk.sv
`timescale 1ns/1ps
`default_nettype none

// Shadow model of the CIN receiver built from its top ports only
module turf_cin_rx_chk
    import cin_link_pkg::*, cin_ctrl_pkg::*;
(
    input wire logic                                rxclk,
    input wire logic                                reset,
    input wire logic [CIN_LANES-1:0][CIN_NIB_W-1:0] cin_raw,
    input wire logic                                cmd_strobe,
    input wire cin_cmd_t                            cmd,
    input wire logic [CIN_LANES*CIN_NIB_W-1:0]      cin_word,
    input wire logic [CIN_LANES-1:0]                aligned,
    input wire logic [CIN_LANES-1:0]                locked,
    input wire logic [CIN_TAP_W-1:0]                rd_tap
);

    // Read by the testbench at the end of the run
    int fail_count = 0;

    // Command pulses one cycle after the strobe
    logic [CIN_LANES-1:0] slip_p;
    logic [CIN_LANES-1:0] srst_p;
    logic [CIN_LANES-1:0] load_p;
    logic [CIN_TAP_W-1:0] load_val;
    logic [CIN_SEL_W-1:0] sel;

    // Per-lane state
    logic [CIN_NIB_W-1:0]  prev [CIN_LANES];
    logic [CIN_SLIP_W-1:0] offs [CIN_LANES];
    logic [CIN_TAP_W-1:0]  taps [CIN_LANES];
    logic [CIN_NIB_W-1:0]  nib  [CIN_LANES];

    // Expected port values
    logic [CIN_LANES*CIN_NIB_W-1:0] exp_word;
    logic [CIN_LANES-1:0]           exp_aligned;
    logic [CIN_LANES-1:0]           exp_locked;
    logic [CIN_TAP_W-1:0]           exp_rd_tap;
    int                             run [CIN_LANES];

    always_ff @(posedge rxclk) begin
        if (reset) begin
            slip_p <= '0;
            srst_p <= '0;
            load_p <= '0;
            load_val <= '0;
            sel <= '0;
        end else begin
            slip_p <= '0;
            srst_p <= '0;
            load_p <= '0;
            if (cmd_strobe) begin
                case (cmd.mask_view.opcode)
                    CMD_LOAD_DELAY: begin
                        load_p   <= CIN_LANES'(1) << cmd.tap_view.lane;
                        load_val <= cmd.tap_view.tap;
                    end
                    CMD_BITSLIP:      slip_p <= cmd.mask_view.lane_mask;
                    CMD_SERDES_RESET: srst_p <= cmd.mask_view.lane_mask;
                    default:          sel    <= cmd.tap_view.lane;
                endcase
            end
        end
    end

    // Window rule on {older, current} with the offset from before this edge's slip
    always_ff @(posedge rxclk) begin
        for (int i = 0; i < CIN_LANES; i++) begin
            if (reset || srst_p[i]) begin
                prev[i] <= '0;
                offs[i] <= '0;
                nib[i]  <= '0;
            end else begin
                prev[i] <= cin_raw[i];
                nib[i]  <= CIN_NIB_W'({prev[i], cin_raw[i]} >> offs[i]);
                offs[i] <= offs[i] + CIN_SLIP_W'(slip_p[i]);
            end
            if (reset) begin
                taps[i] <= '0;
            end else if (load_p[i]) begin
                taps[i] <= load_val;
            end
        end
    end

    // Port stage with lock after CIN_LOCK_COUNT aligned words in a row
    always_ff @(posedge rxclk) begin
        if (reset) begin
            exp_word    <= '0;
            exp_aligned <= '0;
            exp_locked  <= '0;
            exp_rd_tap  <= '0;
            for (int i = 0; i < CIN_LANES; i++) begin
                run[i] <= 0;
            end
        end else begin
            exp_rd_tap <= taps[sel];
            for (int i = 0; i < CIN_LANES; i++) begin
                exp_word[i*CIN_NIB_W +: CIN_NIB_W] <= nib[i];
                exp_aligned[i] <= (nib[i] == CIN_TRAIN);
                if (nib[i] == CIN_TRAIN) begin
                    run[i]        <= (run[i] < CIN_LOCK_COUNT) ? run[i] + 1 : run[i];
                    exp_locked[i] <= (run[i] + 1 >= CIN_LOCK_COUNT);
                end else begin
                    run[i]        <= 0;
                    exp_locked[i] <= 1'b0;
                end
            end
        end
    end

    a_reset_state: assert property (@(posedge rxclk)
        $fell(reset) |=> (cin_word == '0 && aligned == '0 && locked == '0 && rd_tap == '0))
    else begin
        $error("mismatch at %0t: outputs not zero after reset release", $time);
        fail_count++;
    end

    a_word: assert property (@(posedge rxclk) disable iff (reset) cin_word == exp_word)
    else begin
        $error("mismatch at %0t: cin_word %h expected %h", $time, cin_word, exp_word);
        fail_count++;
    end

    a_aligned: assert property (@(posedge rxclk) disable iff (reset) aligned == exp_aligned)
    else begin
        $error("mismatch at %0t: aligned %b expected %b", $time, aligned, exp_aligned);
        fail_count++;
    end

    a_locked: assert property (@(posedge rxclk) disable iff (reset) locked == exp_locked)
    else begin
        $error("mismatch at %0t: locked %b expected %b", $time, locked, exp_locked);
        fail_count++;
    end

    a_rd_tap: assert property (@(posedge rxclk) disable iff (reset) rd_tap == exp_rd_tap)
    else begin
        $error("mismatch at %0t: rd_tap %0d expected %0d", $time, rd_tap, exp_rd_tap);
        fail_count++;
    end

endmodule

bind turf_cin_rx turf_cin_rx_chk chk0 (
    .rxclk      (rxclk),
    .reset      (reset),
    .cin_raw    (cin_raw),
    .cmd_strobe (cmd_strobe),
    .cmd        (cmd),
    .cin_word   (cin_word),
    .aligned    (aligned),
    .locked     (locked),
    .rd_tap     (rd_tap)
);

`default_nettype wire

// File: turf_cin_rx_tb.sv
`timescale 1ns/1ps
`default_nettype none

// Clock, reset and stimulus for the CIN receiver
module turf_cin_rx_tb
    import cin_link_pkg::*, cin_ctrl_pkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 3;
    localparam int SLIP_ROUNDS  = 12;
    localparam int TRAIN_ROUNDS = 8;
    // Worst case cycles per phase from reset through the final reads
    localparam int STIM_CYCLES  = RESET_CYCLES + 22 + SLIP_ROUNDS * 5 + TRAIN_ROUNDS * 7
                                  + 16 + (CIN_LANES + 2) + 2 * CIN_LANES * 3 + 19;
    localparam int TIMEOUT_NS   = (STIM_CYCLES + 100) * CLK_PERIOD;

    logic                                rxclk;
    logic                                reset;
    logic [CIN_LANES-1:0][CIN_NIB_W-1:0] cin_raw;
    logic                                cmd_strobe;
    cin_cmd_t                            cmd;
    logic [CIN_LANES*CIN_NIB_W-1:0]      cin_word;
    logic [CIN_LANES-1:0]                aligned;
    logic [CIN_LANES-1:0]                locked;
    logic [CIN_TAP_W-1:0]                rd_tap;

    int                   seed = 32'h3d13a274;
    int                   errors = 0;
    // Lanes fed a repeating rotated training nibble
    logic [CIN_LANES-1:0] train_mask;
    logic [CIN_NIB_W-1:0] train_nib [CIN_LANES];
    logic [CIN_TAP_W-1:0] tap_val   [CIN_LANES];

    turf_cin_rx dut0 (
        .rxclk      (rxclk),
        .reset      (reset),
        .cin_raw    (cin_raw),
        .cmd_strobe (cmd_strobe),
        .cmd        (cmd),
        .cin_word   (cin_word),
        .aligned    (aligned),
        .locked     (locked),
        .rd_tap     (rd_tap)
    );

    initial begin
        rxclk = 1'b0;
        forever #(CLK_PERIOD / 2) rxclk = ~rxclk;
    end

    function automatic cin_cmd_t mask_cmd(input logic [CMD_OP_W-1:0] op,
                                          input logic [CIN_LANES-1:0] mask);
        cin_cmd_t c;
        c = '0;
        c.mask_view.opcode    = op;
        c.mask_view.lane_mask = mask;
        return c;
    endfunction

    function automatic cin_cmd_t tap_cmd(input logic [CMD_OP_W-1:0] op,
                                         input logic [CIN_SEL_W-1:0] lane,
                                         input logic [CIN_TAP_W-1:0] tap);
        cin_cmd_t c;
        c = '0;
        c.tap_view.opcode = op;
        c.tap_view.lane   = lane;
        c.tap_view.tap    = tap;
        return c;
    endfunction

    // Random nibbles except on training lanes
    task automatic drive_raw();
        logic [31:0] r;
        r = $random(seed);
        for (int i = 0; i < CIN_LANES; i++) begin
            cin_raw[i] = train_mask[i] ? train_nib[i] : r[i*CIN_NIB_W +: CIN_NIB_W];
        end
    endtask

    // One falling edge with optional command
    task automatic tick(input logic strobe, input cin_cmd_t c);
        @(negedge rxclk);
        drive_raw();
        cmd_strobe = strobe;
        cmd        = c;
    endtask

    task automatic idle(input int n);
        repeat (n) tick(1'b0, '0);
    endtask

    // rd_tap is registered one edge after the read is taken
    task automatic read_tap_check(input int lane);
        tick(1'b1, tap_cmd(CMD_READ_TAP, CIN_SEL_W'(lane), '0));
        idle(2);
        if (rd_tap !== tap_val[lane]) begin
            errors++;
            $display("mismatch at %0t: rd_tap lane %0d is %0d, expected %0d",
                     $time, lane, rd_tap, tap_val[lane]);
        end
    endtask

    initial begin
        logic [CIN_LANES-1:0] mask;
        logic [1:0]           k;
        reset      = 1'b1;
        cmd_strobe = 1'b0;
        cmd        = '0;
        cin_raw    = '0;
        train_mask = '0;
        for (int i = 0; i < CIN_LANES; i++) begin
            train_nib[i] = '0;
            tap_val[i]   = '0;
        end
        repeat (RESET_CYCLES) @(posedge rxclk);
        @(negedge rxclk);
        reset = 1'b0;
        drive_raw();

        // Reset state after the first free edge
        tick(1'b0, '0);
        if (cin_word !== '0 || aligned !== '0 || locked !== '0 || rd_tap !== '0) begin
            errors++;
            $display("mismatch at %0t: outputs not zero after reset", $time);
        end

        // Straight path with every offset 0
        idle(20);

        // Random bitslips with some back to back
        repeat (SLIP_ROUNDS) begin
            tick(1'b1, mask_cmd(CMD_BITSLIP, CIN_LANES'($random(seed))));
            if ($random(seed) & 1) begin
                tick(1'b1, mask_cmd(CMD_BITSLIP, CIN_LANES'($random(seed))));
            end
            idle(int'($random(seed)) & 3);
        end

        // Training on every lane but lane 4
        train_mask = 8'hef;
        for (int i = 0; i < CIN_LANES; i++) begin
            k            = 2'($random(seed));
            // Rotate left by k so k slips recover CIN_TRAIN
            train_nib[i] = CIN_NIB_W'({CIN_TRAIN, CIN_TRAIN} >> (CIN_NIB_W - int'(k)));
        end
        tick(1'b1, mask_cmd(CMD_SERDES_RESET, '1));
        for (int r = 0; r < TRAIN_ROUNDS; r++) begin
            idle(6);
            mask = train_mask & ~aligned;
            if (mask == '0) break;
            tick(1'b1, mask_cmd(CMD_BITSLIP, mask));
        end
        if ((aligned & train_mask) != train_mask) begin
            errors++;
            $display("mismatch at %0t: training lanes not aligned, aligned is %b",
                     $time, aligned);
        end
        idle(6);
        if ((locked & train_mask) != train_mask) begin
            errors++;
            $display("mismatch at %0t: locked %b, expected %b set", $time, locked, train_mask);
        end
        // One extra slip on lane 0 breaks its lock
        tick(1'b1, mask_cmd(CMD_BITSLIP, 8'h01));
        idle(6);
        if (locked[0] !== 1'b0) begin
            errors++;
            $display("mismatch at %0t: lane 0 still locked after slip", $time);
        end
        train_mask = '0;

        // Back to back delay loads and then readback
        for (int i = 0; i < CIN_LANES; i++) begin
            tap_val[i] = CIN_TAP_W'($random(seed));
            tick(1'b1, tap_cmd(CMD_LOAD_DELAY, CIN_SEL_W'(i), tap_val[i]));
        end
        idle(2);
        for (int i = 0; i < CIN_LANES; i++) begin
            read_tap_check(i);
        end

        // Deserializer reset on a random mask keeps the taps
        tick(1'b1, mask_cmd(CMD_BITSLIP, CIN_LANES'($random(seed))));
        idle(3);
        tick(1'b1, mask_cmd(CMD_SERDES_RESET, CIN_LANES'($random(seed))));
        idle(10);
        for (int i = 0; i < CIN_LANES; i++) begin
            read_tap_check(i);
        end
        idle(4);

        $display("Summary: %0d testbench errors, %0d assertion failures",
                 errors, dut0.chk0.fail_count);
        if (errors + dut0.chk0.fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Run timed out after %0t before the stimulus finished", $time);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: turf_cin_rx.f
cin_link_pkg.sv
cin_ctrl_pkg.sv
cin_ctrl_decode.sv
cin_lane.sv
cin_capture.sv
turf_cin_rx.sv
turf_cin_rx_chk.sv
turf_cin_rx_tb.sv

// File: Makefile
TOP = turf_cin_rx_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --timing -f turf_cin_rx.f --top-module $(TOP) -o Vtb

run: build
	./obj_dir/Vtb +verilator+error+limit+1000 2>&1 | tee sim.log
	@! grep -q "Errors found" sim.log
	@grep -q "No errors" sim.log

lint:
	verilator --lint-only --timing -f turf_cin_rx.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
